/* tb.f */
rtl/isaPkg.sv
rtl/busPkg.sv
rtl/pipeIf.sv
rtl/instrPort.sv
rtl/RegFile.sv
rtl/aluStage.sv
rtl/writeBack.sv
rtl/execCore.sv
verif/tbModel.sv
verif/tbCore.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbCore -f tb.f -o simTb

output=$(./obj_dir/simTb)
echo "$output"

if echo "$output" | grep -qx "test passed"; then
	exit 0
else
	exit 1
fi

/* verif/tbCore.sv */
`timescale 1ns/1ps

module tbCore;

	localparam int ackTimeout = 100;
	localparam int drainTimeout = 200;
	localparam int randomCount = 60;

	logic clk;
	logic reset;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [3:0] wbAdr;
	logic [31:0] wbDatW;
	logic [31:0] wbDatR;
	logic wbAck;
	logic resultValid;
	logic [4:0] resultDest;
	logic [31:0] resultData;

	integer seed = 32'h7c2d22d1;
	// Expected trace entries in issue order
	logic [4:0] expDest [512];
	logic [31:0] expData [512];
	int issuedValid = 0;
	int retired = 0;
	logic ackLag1 = 1'b0;
	logic ackLag2 = 1'b0;
	logic [5:0] functs [6] = '{isaPkg::fnAdd, isaPkg::fnSub, isaPkg::fnAnd,
		isaPkg::fnOr, isaPkg::fnXor, isaPkg::fnSlt};

	execCore dut (
		.clk(clk),
		.reset(reset),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.resultValid(resultValid),
		.resultDest(resultDest),
		.resultData(resultData)
	);

	// 4 ns clock
	initial clk = 1'b0;
	always #2 clk = ~clk;

	//////////////////////////////
	// Helpers
	//////////////////////////////
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		if (got !== expected)
			abortRun($sformatf("Error at %0t: %s is %h, expected %h",
				$time, what, got, expected));
	endtask

	function automatic logic [31:0] randomWord();
		return $random(seed);
	endfunction

	// Request held through the ack cycle and dropped 1 ns after it
	task automatic waitAck(input string what);
		int waited;
		waited = 0;
		@(posedge clk);
		#1;
		while (!wbAck)
		begin
			waited++;
			if (waited > ackTimeout)
				abortRun($sformatf("No acknowledge for the %s within %0d cycles",
					what, ackTimeout));
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic busWrite(input logic [3:0] adr, input logic [31:0] data);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = 1'b1;
		wbAdr = adr;
		wbDatW = data;
		waitAck("bus write");
	endtask

	// Read data registered on the request edge
	task automatic busRead(input logic [3:0] adr, output logic [31:0] data);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = 1'b0;
		wbAdr = adr;
		waitAck("bus read");
		data = wbDatR;
	endtask

	task automatic issue(input logic [31:0] instr);
		logic valid;
		logic [4:0] dest;
		logic [31:0] value;
		tbModel::refExecute(instr, valid, dest, value);
		busWrite(busPkg::instrAdr, instr);
		if (valid)
		begin
			expDest[issuedValid] = dest;
			expData[issuedValid] = value;
			issuedValid++;
		end
	endtask

	// Wait for every expected entry, then let r31 reach the read register
	task automatic drain();
		int waited;
		waited = 0;
		while (retired != issuedValid)
		begin
			waited++;
			if (waited > drainTimeout)
				abortRun("The trace port did not deliver every expected result in time");
			@(posedge clk);
			#1;
		end
		repeat (3) @(posedge clk);
		#1;
	endtask

	//////////////////////////////
	// Trace compare
	//////////////////////////////
	// Trace settles off the execute register before the falling edge
	always @(negedge clk)
	begin
		if (!reset && resultValid)
		begin
			if (retired >= issuedValid)
				abortRun($sformatf("A trace entry for r%0d appeared that no instruction predicted",
					resultDest));
			else
			begin
				checkValue(32'(resultDest), 32'(expDest[retired]), "trace dest");
				checkValue(resultData, expData[retired], "trace data");
				checkValue(32'(ackLag2), 32'd1, "wbAck two cycles before resultValid");
				retired++;
			end
		end
		ackLag2 = ackLag1;
		ackLag1 = wbAck;
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	initial
	begin
		logic [31:0] word;
		logic [31:0] rdata;
		logic [15:0] imm;
		logic [2:0] kind;
		logic [4:0] prev;
		logic [4:0] next;
		reset = 1'b1;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatW = '0;
		tbModel::modelRegs[0] = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		// Registers come up unknown so load each one
		for (int r = 1; r < 32; r++)
		begin
			word = randomWord();
			issue(tbModel::encodeI(isaPkg::opOri, 5'(r), 5'd0, word[15:0]));
		end
		drain();

		// Random R-type and I-type mix
		for (int i = 0; i < randomCount; i++)
		begin
			word = randomWord();
			kind = word[2:0];
			if (kind < 3'd6)
				issue(tbModel::encodeR(functs[kind], 5'(randomWord()), 5'(randomWord()),
					5'(randomWord())));
			else if (kind == 3'd6)
				issue(tbModel::encodeI(isaPkg::opAddi, 5'(randomWord()), 5'(randomWord()),
					word[31:16]));
			else
				issue(tbModel::encodeI(isaPkg::opOri, 5'(randomWord()), 5'(randomWord()),
					word[31:16]));
		end
		drain();

		// Dependent chains where each rs is the previous dest
		for (int c = 0; c < 4; c++)
		begin
			prev = 5'(randomWord());
			for (int k = 0; k < 6; k++)
			begin
				word = randomWord();
				next = 5'(word[12:8]);
				if (word[2:0] < 3'd6)
					issue(tbModel::encodeR(functs[word[2:0]], next, prev, 5'(randomWord())));
				else
					issue(tbModel::encodeI(isaPkg::opAddi, next, prev, word[31:16]));
				prev = next;
			end
		end
		drain();

		// r0 as dest, then as source
		issue(tbModel::encodeI(isaPkg::opAddi, 5'd0, 5'd5, 16'h1234));
		issue(tbModel::encodeR(isaPkg::fnAdd, 5'd6, 5'd0, 5'd0));
		issue(tbModel::encodeI(isaPkg::opOri, 5'd7, 5'd0, 16'h0055));
		drain();

		// LINK, bus read of r31, then r31 as source
		word = randomWord();
		imm = word[15:0];
		issue(tbModel::encodeLink(imm));
		drain();
		busRead(busPkg::raAdr, rdata);
		checkValue(rdata, {16'd0, imm}, "raAdr read after LINK");
		issue(tbModel::encodeR(isaPkg::fnAdd, 5'd8, 5'd31, 5'd2));
		drain();

		// Undefined ops leave r9 and r10 alone
		issue(tbModel::encodeR(6'h01, 5'd9, 5'd1, 5'd2));
		issue(tbModel::encodeI(6'h3f, 5'd10, 5'd3, 16'hffff));
		busWrite(4'h2, randomWord());
		busRead(4'h3, rdata);
		checkValue(rdata, 32'd0, "read of an unmapped address");
		issue(tbModel::encodeR(isaPkg::fnOr, 5'd11, 5'd9, 5'd10));
		drain();
		busRead(busPkg::raAdr, rdata);
		checkValue(rdata, tbModel::modelRegs[31], "raAdr read at the end");

		if (retired != issuedValid)
			abortRun($sformatf("Trace count %0d differs from %0d valid instructions",
				retired, issuedValid));
		else
		begin
			$display("test passed");
			$finish;
		end
	end

endmodule

/* verif/tbModel.sv */
package tbModel;

	//////////////////////////////
	// Model register array
	//////////////////////////////
	// r0 stays zero, the rest filled by the stimulus
	logic [31:0] modelRegs [32];

	//////////////////////////////
	// Instruction encoders
	//////////////////////////////
	function automatic logic [31:0] encodeR(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {isaPkg::opR, rs, rt, rd, 5'd0, fn};
	endfunction

	// I-type writes rt
	function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encodeLink(input logic [15:0] imm);
		return {isaPkg::opLink, 5'd0, 5'd0, imm};
	endfunction

	//////////////////////////////
	// Reference execution
	//////////////////////////////
	function automatic void refExecute(input logic [31:0] instr, output logic valid,
		output logic [4:0] dest, output logic [31:0] value);
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [15:0] imm;
		logic [31:0] a;
		logic [31:0] b;
		op = instr[31:26];
		rs = instr[25:21];
		rt = instr[20:16];
		rd = instr[15:11];
		imm = instr[15:0];
		fn = instr[5:0];
		a = modelRegs[rs];
		b = modelRegs[rt];
		valid = 1'b1;
		dest = rt;
		value = '0;
		case (op)
			isaPkg::opR:
			begin
				dest = rd;
				case (fn)
					isaPkg::fnAdd: value = a + b;
					isaPkg::fnSub: value = a - b;
					isaPkg::fnAnd: value = a & b;
					isaPkg::fnOr: value = a | b;
					isaPkg::fnXor: value = a ^ b;
					isaPkg::fnSlt: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					// Unknown funct retires as NOP
					default: valid = 1'b0;
				endcase
			end
			// Sign extended immediate
			isaPkg::opAddi: value = a + {{16{imm[15]}}, imm};
			isaPkg::opOri: value = a | {16'd0, imm};
			isaPkg::opLink:
			begin
				dest = 5'd31;
				value = {16'd0, imm};
			end
			default: valid = 1'b0;
		endcase
		// Trace shows r0 writes, the register keeps zero
		if (valid && (dest != 5'd0))
			modelRegs[dest] = value;
	endfunction

endpackage

/* rtl/execCore.sv */
`timescale 1ns/1ps

module execCore (
	input logic clk,
	input logic reset,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [busPkg::adrWidth-1:0] wbAdr,
	input logic [busPkg::datWidth-1:0] wbDatW,
	output logic [busPkg::datWidth-1:0] wbDatR,
	output logic wbAck,
	output logic resultValid,
	output logic [isaPkg::regBits-1:0] resultDest,
	output logic [isaPkg::dataWidth-1:0] resultData
);

	// Register file read data
	logic [isaPkg::dataWidth-1:0] RsData;
	logic [isaPkg::dataWidth-1:0] RtData;
	logic [isaPkg::dataWidth-1:0] RaData;

	//////////////////////////////
	// Pipeline links
	//////////////////////////////
	decodeIf decBus ();
	execIf exBus ();
	writeIf wrBus ();

	// Bus slave, scoreboard and decode
	instrPort port (
		.clk(clk),
		.reset(reset),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.raData(RaData),
		.dec(decBus.source),
		.wr(wrBus.sink)
	);

	RegFile regs (
		.clk(clk),
		.reset(reset),
		.dec(decBus.regRead),
		.wr(wrBus.sink),
		.RsData(RsData),
		.RtData(RtData),
		.RaData(RaData)
	);

	aluStage alu (
		.clk(clk),
		.reset(reset),
		.dec(decBus.execute),
		.RsData(RsData),
		.RtData(RtData),
		.ex(exBus.source)
	);

	// Write steering and trace
	writeBack wb (
		.clk(clk),
		.reset(reset),
		.ex(exBus.sink),
		.wr(wrBus.source),
		.resultValid(resultValid),
		.resultDest(resultDest),
		.resultData(resultData)
	);

endmodule

/* rtl/writeBack.sv */
`timescale 1ns/1ps

module writeBack (
	input logic clk,
	input logic reset,
	execIf.sink ex,
	writeIf.source wr,
	output logic resultValid,
	output logic [isaPkg::regBits-1:0] resultDest,
	output logic [isaPkg::dataWidth-1:0] resultData
);

	logic [isaPkg::regBits-1:0] dest;

	//////////////////////////////
	// Write steering
	//////////////////////////////
	// LINK always lands in r31
	assign dest = ex.isLink ? isaPkg::raIndex : ex.dest;

	// General register path
	assign wr.regWriteEn = ex.valid && ex.writesReg;
	// Return address path
	assign wr.raWriteEn = ex.valid && ex.isLink;
	assign wr.rdest = dest;
	assign wr.writeData = ex.data;

	//////////////////////////////
	// Trace port
	//////////////////////////////
	// Same cycle as the register write
	// r0 writes still show their value here
	assign resultValid = ex.valid;
	assign resultDest = dest;
	assign resultData = ex.data;

	// Each retirement drives exactly one write path
	retireWrites: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> (wr.regWriteEn ^ wr.raWriteEn));

endmodule

/* rtl/aluStage.sv */
`timescale 1ns/1ps

module aluStage (
	input logic clk,
	input logic reset,
	decodeIf.execute dec,
	input logic [isaPkg::dataWidth-1:0] RsData,
	input logic [isaPkg::dataWidth-1:0] RtData,
	execIf.source ex
);

	// Decoded fields delayed to line up with read data
	logic validQ;
	logic [isaPkg::opBits-1:0] opQ;
	logic [isaPkg::regBits-1:0] rdestQ;
	logic [isaPkg::immBits-1:0] immQ;
	isaPkg::aluOp sel;
	logic [isaPkg::dataWidth-1:0] immSext;
	logic [isaPkg::dataWidth-1:0] immZext;
	logic [isaPkg::dataWidth-1:0] operandB;
	logic [isaPkg::dataWidth-1:0] result;
	logic lessThan;

	//////////////////////////////
	// Field alignment
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
			validQ <= 1'b0;
		else
			validQ <= dec.valid;
	end

	always_ff @(posedge clk)
	begin
		opQ <= dec.op;
		rdestQ <= dec.rdest;
		immQ <= dec.imm;
	end

	assign sel = isaPkg::decodeOp(opQ, immQ[isaPkg::fnBits-1:0]);

	// ADDI sign extends, ORI and LINK zero extend
	assign immSext = {{(isaPkg::dataWidth-isaPkg::immBits){immQ[isaPkg::immBits-1]}}, immQ};
	assign immZext = {{(isaPkg::dataWidth-isaPkg::immBits){1'b0}}, immQ};

	always_comb
	begin
		if (opQ == isaPkg::opR)
			operandB = RtData;
		else if (opQ == isaPkg::opAddi)
			operandB = immSext;
		else
			operandB = immZext;
	end

	//////////////////////////////
	// ALU
	//////////////////////////////
	assign lessThan = $signed(RsData) < $signed(operandB);

	always_comb
	begin
		case (sel)
			isaPkg::aluAdd: result = RsData + operandB;
			isaPkg::aluSub: result = RsData - operandB;
			isaPkg::aluAnd: result = RsData & operandB;
			isaPkg::aluOr: result = RsData | operandB;
			isaPkg::aluXor: result = RsData ^ operandB;
			isaPkg::aluSlt: result = {{(isaPkg::dataWidth-1){1'b0}}, lessThan};
			// Immediate passes straight through
			isaPkg::aluLink: result = operandB;
			default: result = '0;
		endcase
	end

	// Undefined ops retire with valid low
	always_ff @(posedge clk)
	begin
		if (reset)
			ex.valid <= 1'b0;
		else
			ex.valid <= validQ && (sel != isaPkg::aluNop);
	end

	always_ff @(posedge clk)
	begin
		ex.dest <= rdestQ;
		ex.data <= result;
		ex.isLink <= (sel == isaPkg::aluLink);
		ex.writesReg <= (sel != isaPkg::aluLink) && (sel != isaPkg::aluNop);
	end

endmodule

/* rtl/RegFile.sv */
`timescale 1ns/1ps

module RegFile (
	input logic clk,
	input logic reset,
	decodeIf.regRead dec,
	writeIf.sink wr,
	output logic [isaPkg::dataWidth-1:0] RsData,
	output logic [isaPkg::dataWidth-1:0] RtData,
	output logic [isaPkg::dataWidth-1:0] RaData
);

	// 32 general registers
	logic [isaPkg::dataWidth-1:0] regs [isaPkg::regCount];

	//////////////////////////////
	// Write paths
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		// r0 forced back to zero every clock
		regs[0] <= '0;
		// Writes aimed at r0 dropped here
		if (wr.regWriteEn && (wr.rdest != '0))
			regs[wr.rdest] <= wr.writeData;
		// Return address path
		if (wr.raWriteEn)
			regs[isaPkg::raIndex] <= wr.writeData;
	end

	//////////////////////////////
	// Registered reads
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			RsData <= '0;
			RtData <= '0;
			RaData <= '0;
		end
		else
		begin
			RsData <= regs[dec.rs];
			RtData <= regs[dec.rt];
			// r31 always visible for bus reads
			RaData <= regs[isaPkg::raIndex];
		end
	end

	oneWritePath: assert property (@(posedge clk) disable iff (reset)
		!(wr.regWriteEn && wr.raWriteEn));

endmodule

/* rtl/instrPort.sv */
`timescale 1ns/1ps

module instrPort (
	input logic clk,
	input logic reset,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [busPkg::adrWidth-1:0] wbAdr,
	input logic [busPkg::datWidth-1:0] wbDatW,
	output logic [busPkg::datWidth-1:0] wbDatR,
	output logic wbAck,
	input logic [isaPkg::dataWidth-1:0] raData,
	decodeIf.source dec,
	writeIf.sink wr
);

	// One pending bit per register
	logic [isaPkg::regCount-1:0] pending;
	logic [isaPkg::regCount-1:0] pendingNext;
	logic [isaPkg::opBits-1:0] opcode;
	logic [isaPkg::regBits-1:0] rs;
	logic [isaPkg::regBits-1:0] rt;
	logic [isaPkg::regBits-1:0] rd;
	logic [isaPkg::regBits-1:0] dest;
	logic [isaPkg::immBits-1:0] imm;
	isaPkg::aluOp sel;
	logic request;
	logic isInstr;
	logic writesDest;
	logic usesRs;
	logic usesRt;
	logic hazard;
	logic accept;

	//////////////////////////////
	// Field split
	//////////////////////////////
	assign opcode = wbDatW[isaPkg::opLsb +: isaPkg::opBits];
	assign rs = wbDatW[isaPkg::rsLsb +: isaPkg::regBits];
	assign rt = wbDatW[isaPkg::rtLsb +: isaPkg::regBits];
	assign rd = wbDatW[isaPkg::rdLsb +: isaPkg::regBits];
	assign imm = wbDatW[isaPkg::immBits-1:0];
	assign sel = isaPkg::decodeOp(opcode, imm[isaPkg::fnBits-1:0]);

	// R-type writes rd, I-type writes rt, LINK writes r31
	always_comb
	begin
		if (opcode == isaPkg::opR)
			dest = rd;
		else if (opcode == isaPkg::opLink)
			dest = isaPkg::raIndex;
		else
			dest = rt;
	end

	// NOPs touch no register
	assign writesDest = (sel != isaPkg::aluNop);
	assign usesRs = writesDest && (sel != isaPkg::aluLink);
	assign usesRt = writesDest && (opcode == isaPkg::opR);

	//////////////////////////////
	// Request and hazard check
	//////////////////////////////
	// Ack cycle still shows cyc and stb, skip it
	assign request = wbCyc && wbStb && !wbAck;
	assign isInstr = wbWe && (wbAdr == busPkg::instrAdr);
	// Destination check too, keeps two writes to one register apart
	assign hazard = (usesRs && pending[rs]) || (usesRt && pending[rt])
		|| (writesDest && pending[dest]);
	assign accept = request && isInstr && !hazard;

	// Clear first so a same-edge set wins
	always_comb
	begin
		pendingNext = pending;
		if (wr.regWriteEn || wr.raWriteEn)
			pendingNext[wr.rdest] = 1'b0;
		if (accept && writesDest)
			pendingNext[dest] = 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pending <= '0;
			wbAck <= 1'b0;
			dec.valid <= 1'b0;
		end
		else
		begin
			pending <= pendingNext;
			// Reads and other writes answer right away
			wbAck <= accept || (request && !isInstr);
			dec.valid <= accept;
		end
	end

	// Decode register and read data
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			dec.op <= opcode;
			dec.rs <= rs;
			dec.rt <= rt;
			dec.rdest <= dest;
			dec.imm <= imm;
		end
		if (request && !wbWe)
			wbDatR <= (wbAdr == busPkg::raAdr) ? raData : '0;
	end

	ackNeedsRequest: assert property (@(posedge clk) disable iff (reset)
		wbAck |-> wbCyc && wbStb);

	// Every retirement matches an earlier claim
	writeWasPending: assert property (@(posedge clk) disable iff (reset)
		(wr.regWriteEn || wr.raWriteEn) |-> pending[wr.rdest]);

endmodule

/* rtl/pipeIf.sv */
`timescale 1ns/1ps

//////////////////////////////
// Decode register to operand read and execute
//////////////////////////////
interface decodeIf ();
	logic valid;
	logic [isaPkg::opBits-1:0] op;
	logic [isaPkg::regBits-1:0] rs;
	logic [isaPkg::regBits-1:0] rt;
	logic [isaPkg::regBits-1:0] rdest;
	// Low half of the word, funct sits in its bottom bits
	logic [isaPkg::immBits-1:0] imm;

	modport source (output valid, op, rs, rt, rdest, imm);
	// Register file only needs the source indices
	modport regRead (input rs, rt);
	modport execute (input valid, op, rdest, imm);
endinterface

//////////////////////////////
// Execute result to write back
//////////////////////////////
interface execIf ();
	logic valid;
	logic [isaPkg::regBits-1:0] dest;
	logic [isaPkg::dataWidth-1:0] data;
	logic isLink;
	logic writesReg;

	modport source (output valid, dest, data, isLink, writesReg);
	modport sink (input valid, dest, data, isLink, writesReg);
endinterface

//////////////////////////////
// Register file write paths
//////////////////////////////
interface writeIf ();
	logic regWriteEn;
	logic raWriteEn;
	logic [isaPkg::regBits-1:0] rdest;
	logic [isaPkg::dataWidth-1:0] writeData;

	modport source (output regWriteEn, raWriteEn, rdest, writeData);
	// Register file and scoreboard both listen here
	modport sink (input regWriteEn, raWriteEn, rdest, writeData);
endinterface

/* rtl/busPkg.sv */
package busPkg;

	//////////////////////////////
	// Wishbone widths
	//////////////////////////////
	localparam int adrWidth = 4;
	localparam int datWidth = 32;

	//////////////////////////////
	// Address map
	//////////////////////////////
	// Write issues one instruction word
	localparam logic [adrWidth-1:0] instrAdr = 4'h0;
	// Read returns the return-address register
	localparam logic [adrWidth-1:0] raAdr = 4'h1;

endpackage

/* rtl/isaPkg.sv */
package isaPkg;

	//////////////////////////////
	// Widths
	//////////////////////////////
	localparam int regBits = 5;
	localparam int regCount = 1 << regBits;
	localparam int dataWidth = 32;
	// Register 31 holds the return address
	localparam logic [regBits-1:0] raIndex = regBits'(regCount - 1);

	// Instruction field positions
	localparam int opBits = 6;
	localparam int fnBits = 6;
	localparam int immBits = 16;
	localparam int opLsb = 26;
	localparam int rsLsb = 21;
	localparam int rtLsb = 16;
	localparam int rdLsb = 11;

	//////////////////////////////
	// Opcodes and funct codes
	//////////////////////////////
	localparam logic [opBits-1:0] opR = 6'h00;
	localparam logic [opBits-1:0] opLink = 6'h03;
	localparam logic [opBits-1:0] opAddi = 6'h08;
	localparam logic [opBits-1:0] opOri = 6'h0d;

	localparam logic [fnBits-1:0] fnAdd = 6'h20;
	localparam logic [fnBits-1:0] fnSub = 6'h22;
	localparam logic [fnBits-1:0] fnAnd = 6'h24;
	localparam logic [fnBits-1:0] fnOr = 6'h25;
	localparam logic [fnBits-1:0] fnXor = 6'h26;
	localparam logic [fnBits-1:0] fnSlt = 6'h2a;

	// ALU operation, aluNop marks anything undefined
	typedef enum logic [2:0] {
		aluNop,
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluLink
	} aluOp;

	// Opcode and funct to ALU operation
	function automatic aluOp decodeOp(input logic [opBits-1:0] op, input logic [fnBits-1:0] fn);
		aluOp sel;
		sel = aluNop;
		if (op == opR)
		begin
			case (fn)
				fnAdd: sel = aluAdd;
				fnSub: sel = aluSub;
				fnAnd: sel = aluAnd;
				fnOr: sel = aluOr;
				fnXor: sel = aluXor;
				fnSlt: sel = aluSlt;
				default: sel = aluNop;
			endcase
		end
		else if (op == opAddi)
			sel = aluAdd;
		else if (op == opOri)
			sel = aluOr;
		else if (op == opLink)
			sel = aluLink;
		return sel;
	endfunction

endpackage
